// ==== hw/node_info_fifo.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

module node_info_fifo import spmm_pkg::*; #(
  parameter int DEPTH = `SPMM_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push_i,
  input  node_info_t din_i,
  input  logic       pop_i,
  output node_info_t dout_o,
  output logic       full_o,
  output logic       empty_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  node_info_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // head entry is visible without a read cycle
  assign dout_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(push_i && full_o));
  assert property (@(posedge clk) disable iff (!rst_n) !(pop_i && empty_o));

endmodule

// ==== hw/row_reader.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

module row_reader import spmm_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start_i,
  input  logic [`SPMM_INFO_ADDR_W-1:0] num_rows_i,
  output logic [`SPMM_INFO_ADDR_W-1:0] info_addr_o,
  input  node_info_t                   info_dout_i,
  output logic [`SPMM_H_ADDR_W-1:0]    h_addr_o,
  input  nz_t                          h_dout_i,
  output logic                         fifo_push_o,
  output node_info_t                   fifo_din_o,
  input  logic                         fifo_full_i,
  spmm_nz_if.producer                  nz,
  output logic                         done_o
);

  reader_state_e                state_q;
  logic [`SPMM_INFO_ADDR_W-1:0] rows_left_q;
  logic [`SPMM_INFO_ADDR_W-1:0] info_addr_q;
  logic [`SPMM_H_ADDR_W-1:0]    h_addr_q;
  logic [`SPMM_ROW_LEN_W-1:0]   nz_left_q;
  logic                         vld_q;
  logic                         last_q;
  nz_t                          nz_q;

  // addresses stay put while waiting, so memory data stays valid too
  assign info_addr_o = info_addr_q;
  assign h_addr_o    = h_addr_q;

  assign fifo_push_o = (state_q == RD_INFO_WAIT) && !fifo_full_i;
  assign fifo_din_o  = info_dout_i;

  assign nz.nz_vld  = vld_q;
  assign nz.col_idx = nz_q.col_idx;
  assign nz.val     = nz_q.val;
  assign nz.last    = last_q;

  assign done_o = (state_q == RD_DONE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= RD_IDLE;
      rows_left_q <= '0;
      info_addr_q <= '0;
      h_addr_q    <= '0;
      nz_left_q   <= '0;
      vld_q       <= 1'b0;
      last_q      <= 1'b0;
    end else begin
      case (state_q)
        RD_IDLE, RD_DONE: begin
          if (start_i) begin
            rows_left_q <= num_rows_i;
            info_addr_q <= '0;
            h_addr_q    <= '0;
            state_q     <= (num_rows_i == '0) ? RD_DONE : RD_INFO_FETCH;
          end
        end
        RD_INFO_FETCH: begin
          state_q <= RD_INFO_WAIT;
        end
        RD_INFO_WAIT: begin
          // header goes into the fifo on the first free cycle
          if (!fifo_full_i) begin
            nz_left_q   <= info_dout_i.row_len;
            info_addr_q <= info_addr_q + 1'b1;
            state_q     <= RD_NZ_FETCH;
          end
        end
        RD_NZ_FETCH: begin
          state_q <= RD_NZ_PRESENT;
        end
        RD_NZ_PRESENT: begin
          if (!vld_q) begin
            vld_q  <= 1'b1;
            last_q <= (nz_left_q == 'd1);
          end else if (nz.nz_rdy) begin
            vld_q     <= 1'b0;
            h_addr_q  <= h_addr_q + 1'b1;
            nz_left_q <= nz_left_q - 1'b1;
            if (last_q) begin
              rows_left_q <= rows_left_q - 1'b1;
              state_q     <= (rows_left_q == 'd1) ? RD_DONE : RD_INFO_FETCH;
            end else begin
              state_q <= RD_NZ_FETCH;
            end
          end
        end
        default: begin
          state_q <= RD_IDLE;
        end
      endcase
    end
  end

  // nonzero payload, captured the cycle after its address went out
  always_ff @(posedge clk) begin
    if (state_q == RD_NZ_PRESENT && !vld_q) begin
      nz_q <= h_dout_i;
    end
  end

  // empty rows would never produce a last and hang the consumer
  assert property (@(posedge clk) disable iff (!rst_n)
    fifo_push_o |-> (fifo_din_o.row_len != '0));

endmodule

// ==== hw/sp_pe.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

module sp_pe (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           mac_en_i,
  input  logic                           clear_i,
  input  logic [`SPMM_COL_IDX_W-1:0]     col_idx_i,
  input  logic signed [`SPMM_DATA_W-1:0] val_i,
  output logic [`SPMM_COL_IDX_W-1:0]     wgt_addr_o,
  input  logic signed [`SPMM_DATA_W-1:0] wgt_dout_i,
  output logic signed [`SPMM_ACC_W-1:0]  acc_o
);

  localparam int PROD_W = 2 * `SPMM_DATA_W;

  logic                          en_q;
  logic signed [`SPMM_DATA_W-1:0] val_q;
  logic signed [PROD_W-1:0]       prod;
  logic signed [`SPMM_ACC_W-1:0]  base;

  // weight row is the nonzero's column
  assign wgt_addr_o = col_idx_i;

  assign prod = val_q * wgt_dout_i;
  // a clear together with an addition starts the next row's sum
  assign base = clear_i ? '0 : acc_o;

  // value waits one cycle for the weight read
  always_ff @(posedge clk) begin
    if (mac_en_i) begin
      val_q <= val_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_q  <= 1'b0;
      acc_o <= '0;
    end else begin
      en_q <= mac_en_i;
      if (en_q) begin
        acc_o <= base + {{(`SPMM_ACC_W - PROD_W){prod[PROD_W-1]}}, prod};
      end else if (clear_i) begin
        acc_o <= '0;
      end
    end
  end

endmodule

// ==== hw/spmm_nz_if.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

// nonzero stream, payload holds while nz_vld waits for nz_rdy
interface spmm_nz_if;

  logic                           nz_vld;
  logic                           nz_rdy;
  logic [`SPMM_COL_IDX_W-1:0]     col_idx;
  logic signed [`SPMM_DATA_W-1:0] val;
  // final nonzero of the current row
  logic                           last;

  modport producer (
    output nz_vld, col_idx, val, last,
    input  nz_rdy
  );

  modport consumer (
    input  nz_vld, col_idx, val, last,
    output nz_rdy
  );

endinterface

// ==== hw/spmm_pkg.sv ====
`include "spmm_settings.svh"

package spmm_pkg;

  // node_info memory word and fifo entry
  typedef struct packed {
    logic [`SPMM_ROW_LEN_W-1:0] row_len;
    logic [`SPMM_NODE_ID_W-1:0] node_id;
    logic                       src_flag;
  } node_info_t;

  // h_data memory word, one per nonzero
  typedef struct packed {
    logic [`SPMM_COL_IDX_W-1:0]    col_idx;
    logic signed [`SPMM_DATA_W-1:0] val;
  } nz_t;

  // result record, lane 0 sits in the top bits
  typedef struct packed {
    logic [0:`SPMM_NUM_COLS-1][`SPMM_ACC_W-1:0] acc;
    logic [`SPMM_NODE_ID_W-1:0]                 node_id;
    logic                                       src_flag;
  } wh_t;

  typedef enum logic [2:0] {
    RD_IDLE,
    RD_INFO_FETCH,
    RD_INFO_WAIT,
    RD_NZ_FETCH,
    RD_NZ_PRESENT,
    RD_DONE
  } reader_state_e;

endpackage

// ==== hw/spmm_settings.svh ====
`ifndef SPMM_SETTINGS_SVH
`define SPMM_SETTINGS_SVH

// lane count, one lane per weight column
`define SPMM_NUM_COLS 4

// signed value and weight width
`define SPMM_DATA_W 8

// 16 weight rows
`define SPMM_COL_IDX_W 4

`define SPMM_ROW_LEN_W 4
`define SPMM_NODE_ID_W 8

// wide enough that a full row of products cannot overflow
`define SPMM_ACC_W 20

// memory address widths
`define SPMM_H_ADDR_W 8
`define SPMM_INFO_ADDR_W 6
`define SPMM_WH_ADDR_W 6

`define SPMM_FIFO_DEPTH 4

`endif

// ==== hw/spmm_top.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

module spmm_top import spmm_pkg::*; (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          start_i,
  input  logic [`SPMM_INFO_ADDR_W-1:0]                  num_rows_i,
  output logic                                          done_o,
  output logic [`SPMM_INFO_ADDR_W-1:0]                  info_addr_o,
  input  node_info_t                                    info_dout_i,
  output logic [`SPMM_H_ADDR_W-1:0]                     h_addr_o,
  input  nz_t                                           h_dout_i,
  output logic [`SPMM_NUM_COLS-1:0][`SPMM_COL_IDX_W-1:0] wgt_addr_o,
  input  logic [`SPMM_NUM_COLS-1:0][`SPMM_DATA_W-1:0]    wgt_dout_i,
  output wh_t                                           wh_din_o,
  output logic                                          wh_ena_o,
  output logic [`SPMM_WH_ADDR_W-1:0]                    wh_addr_o,
  output wh_t                                           wh_data_o
);

  spmm_nz_if  nz_if ();

  logic       fifo_push;
  logic       fifo_pop;
  logic       fifo_full;
  logic       fifo_empty;
  logic       rdr_done;
  node_info_t fifo_din;
  node_info_t fifo_dout;

  row_reader u_row_reader (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_rows_i  (num_rows_i),
    .info_addr_o (info_addr_o),
    .info_dout_i (info_dout_i),
    .h_addr_o    (h_addr_o),
    .h_dout_i    (h_dout_i),
    .fifo_push_o (fifo_push),
    .fifo_din_o  (fifo_din),
    .fifo_full_i (fifo_full),
    .nz          (nz_if.producer),
    .done_o      (rdr_done)
  );

  node_info_fifo #(
    .DEPTH (`SPMM_FIFO_DEPTH)
  ) u_node_info_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (fifo_push),
    .din_i   (fifo_din),
    .pop_i   (fifo_pop),
    .dout_o  (fifo_dout),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  sppe_array u_sppe_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .nz           (nz_if.consumer),
    .fifo_pop_o   (fifo_pop),
    .fifo_dout_i  (fifo_dout),
    .fifo_empty_i (fifo_empty),
    .wgt_addr_o   (wgt_addr_o),
    .wgt_dout_i   (wgt_dout_i),
    .wh_din_o     (wh_din_o),
    .wh_ena_o     (wh_ena_o),
    .wh_addr_o    (wh_addr_o),
    .wh_data_o    (wh_data_o)
  );

  // last header leaves the fifo with the final write
  assign done_o = rdr_done && fifo_empty;

endmodule

// ==== hw/sppe_array.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

module sppe_array import spmm_pkg::*; (
  input  logic                                          clk,
  input  logic                                          rst_n,
  spmm_nz_if.consumer                                   nz,
  output logic                                          fifo_pop_o,
  input  node_info_t                                    fifo_dout_i,
  input  logic                                          fifo_empty_i,
  output logic [`SPMM_NUM_COLS-1:0][`SPMM_COL_IDX_W-1:0] wgt_addr_o,
  input  logic [`SPMM_NUM_COLS-1:0][`SPMM_DATA_W-1:0]    wgt_dout_i,
  output wh_t                                           wh_din_o,
  output logic                                          wh_ena_o,
  output logic [`SPMM_WH_ADDR_W-1:0]                    wh_addr_o,
  output wh_t                                           wh_data_o
);

  logic                                       xfer;
  // last flag lined up with the addition, then with the write
  logic                                       last_q1;
  logic                                       last_q2;
  logic [`SPMM_NUM_COLS-1:0][`SPMM_ACC_W-1:0] lane_acc;
  logic [`SPMM_WH_ADDR_W-1:0]                 wh_addr_q;
  wh_t                                        wh_data_q;

  assign xfer = nz.nz_vld && nz.nz_rdy;

  // hold off the next row until the finished sums are written
  assign nz.nz_rdy = !(last_q1 || last_q2);

  for (genvar g = 0; g < `SPMM_NUM_COLS; g++) begin : g_lane
    sp_pe u_sp_pe (
      .clk        (clk),
      .rst_n      (rst_n),
      .mac_en_i   (xfer),
      .clear_i    (wh_ena_o),
      .col_idx_i  (nz.col_idx),
      .val_i      (nz.val),
      .wgt_addr_o (wgt_addr_o[g]),
      .wgt_dout_i (wgt_dout_i[g]),
      .acc_o      (lane_acc[g])
    );
  end

  always_comb begin
    for (int i = 0; i < `SPMM_NUM_COLS; i++) begin
      wh_din_o.acc[i] = lane_acc[i];
    end
    wh_din_o.node_id  = fifo_dout_i.node_id;
    wh_din_o.src_flag = fifo_dout_i.src_flag;
  end

  assign wh_ena_o   = last_q2;
  assign fifo_pop_o = last_q2;
  assign wh_addr_o  = wh_addr_q;

  // shows the record being written, else the previous one
  assign wh_data_o = wh_ena_o ? wh_din_o : wh_data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_q1   <= 1'b0;
      last_q2   <= 1'b0;
      wh_addr_q <= '0;
      wh_data_q <= '0;
    end else begin
      last_q1 <= xfer && nz.last;
      last_q2 <= last_q1;
      if (wh_ena_o) begin
        wh_addr_q <= wh_addr_q + 1'b1;
        wh_data_q <= wh_din_o;
      end
    end
  end

  // header of the row being written must already be queued
  assert property (@(posedge clk) disable iff (!rst_n)
    wh_ena_o |-> !fifo_empty_i);

endmodule

// ==== list.f ====
+incdir+hw
hw/spmm_pkg.sv
hw/spmm_nz_if.sv
hw/row_reader.sv
hw/node_info_fifo.sv
hw/sp_pe.sv
hw/sppe_array.sv
hw/spmm_top.sv
testbench/tb_spmm_mems.sv
testbench/tb_spmm.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_spmm -o tb_spmm \
  && ./obj_dir/tb_spmm > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q 'Test failures found' sim.log && exit 1 || exit 0

// ==== testbench/tb_spmm.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

module tb_spmm import spmm_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int NUM_CASES       = 5;
  localparam int NUM_ROWS        = 14;
  localparam int NZ_TOTAL        = 31;
  localparam int WATCHDOG_CYCLES = 50 * NZ_TOTAL + 200;

  // cases: name, first row, row count, first nonzero
  string case_name [NUM_CASES] = '{"single_nz", "mixed_rows", "negative_vals",
                                   "fifo_burst", "restart"};
  int case_row0 [NUM_CASES] = '{0, 1, 4, 6, 13};
  int case_rows [NUM_CASES] = '{1, 3, 2, 7, 1};
  int case_nz0  [NUM_CASES] = '{0, 1, 7, 11, 29};

  // rows: length, node id, source flag
  int row_len_tab [NUM_ROWS] = '{1, 3, 1, 2, 2, 2, 1, 1, 1, 1, 1, 1, 12, 2};
  int node_id_tab [NUM_ROWS] = '{'h11, 'h20, 'h21, 'h22, 'h30, 'h31, 'h40, 'h41,
                                 'h42, 'h43, 'h44, 'h45, 'h46, 'h50};
  int src_tab     [NUM_ROWS] = '{1, 0, 1, 0, 1, 0, 0, 1, 0, 1, 0, 1, 1, 1};

  // nonzeros: column and signed value
  int nz_col [NZ_TOTAL] = '{3, 0, 5, 15, 7, 2, 9, 1, 4, 6, 11, 0, 3, 6, 9, 12, 15,
                            0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 3, 8};
  int nz_val [NZ_TOTAL] = '{5, 1, 2, 3, -4, 9, 1, -128, -1, -7, 127,
                            10, -20, 30, -40, 50, -60,
                            1, -2, 3, -4, 5, -6, 7, -8, 9, -10, 11, -12, 5, 2};

  logic                                          clk = 1'b0;
  logic                                          rst_n;
  logic                                          start;
  logic [`SPMM_INFO_ADDR_W-1:0]                  num_rows;
  logic                                          done;
  logic [`SPMM_INFO_ADDR_W-1:0]                  info_addr;
  node_info_t                                    info_dout;
  logic [`SPMM_H_ADDR_W-1:0]                     h_addr;
  nz_t                                           h_dout;
  logic [`SPMM_NUM_COLS-1:0][`SPMM_COL_IDX_W-1:0] wgt_addr;
  logic [`SPMM_NUM_COLS-1:0][`SPMM_DATA_W-1:0]    wgt_dout;
  wh_t                                           wh_din;
  logic                                          wh_ena;
  logic [`SPMM_WH_ADDR_W-1:0]                    wh_addr;
  wh_t                                           wh_data;
  wh_t                                           exp_q [$];
  int                                            errors;
  int                                            rec_base;

  always #(CLK_PERIOD / 2) clk = ~clk;

  spmm_top u_spmm_top (
    .clk (clk), .rst_n (rst_n), .start_i (start), .num_rows_i (num_rows),
    .done_o (done), .info_addr_o (info_addr), .info_dout_i (info_dout),
    .h_addr_o (h_addr), .h_dout_i (h_dout), .wgt_addr_o (wgt_addr),
    .wgt_dout_i (wgt_dout), .wh_din_o (wh_din), .wh_ena_o (wh_ena),
    .wh_addr_o (wh_addr), .wh_data_o (wh_data)
  );

  tb_spmm_mems u_mems (
    .clk (clk), .info_addr_i (info_addr), .info_dout_o (info_dout),
    .h_addr_i (h_addr), .h_dout_o (h_dout), .wgt_addr_i (wgt_addr),
    .wgt_dout_o (wgt_dout), .wh_din_i (wh_din), .wh_ena_i (wh_ena), .wh_addr_i (wh_addr)
  );

  // each case starts at address 0 of both input memories
  task automatic load_memories(input int c);
    node_info_t info;
    nz_t        nzw;
    for (int r = 0; r < case_rows[c]; r++) begin
      info.row_len  = `SPMM_ROW_LEN_W'(row_len_tab[case_row0[c] + r]);
      info.node_id  = `SPMM_NODE_ID_W'(node_id_tab[case_row0[c] + r]);
      info.src_flag = 1'(src_tab[case_row0[c] + r]);
      u_mems.info_mem[r] = info;
    end
    for (int k = 0; k < NZ_TOTAL - case_nz0[c]; k++) begin
      nzw.col_idx   = `SPMM_COL_IDX_W'(nz_col[case_nz0[c] + k]);
      nzw.val       = `SPMM_DATA_W'(nz_val[case_nz0[c] + k]);
      u_mems.h_mem[k] = nzw;
    end
  endtask

  // lane sum is value times the weight at that column, over the row
  task automatic compute_expected(input int c);
    int  nz_idx;
    int  row;
    int  sum;
    wh_t rec;
    nz_idx = case_nz0[c];
    exp_q.delete();
    for (int r = 0; r < case_rows[c]; r++) begin
      row = case_row0[c] + r;
      rec = '0;
      for (int l = 0; l < `SPMM_NUM_COLS; l++) begin
        sum = 0;
        for (int k = 0; k < row_len_tab[row]; k++) begin
          sum += nz_val[nz_idx + k] * int'(u_mems.wgt_mem[nz_col[nz_idx + k]][l]);
        end
        rec.acc[l] = sum[`SPMM_ACC_W-1:0];
      end
      rec.node_id  = `SPMM_NODE_ID_W'(node_id_tab[row]);
      rec.src_flag = 1'(src_tab[row]);
      nz_idx += row_len_tab[row];
      exp_q.push_back(rec);
    end
  endtask

  task automatic check_results(input int c);
    int n;
    n = case_rows[c];
    if (u_mems.wh_count != rec_base + n) begin
      errors++;
      $display("Mismatch %s write count: expected %0d, actual %0d",
               case_name[c], rec_base + n, u_mems.wh_count);
    end
    for (int r = 0; r < n; r++) begin
      if (u_mems.wh_mem[rec_base + r] !== exp_q[r]) begin
        errors++;
        $display("Mismatch %s record %0d: expected %h, actual %h",
                 case_name[c], r, exp_q[r], u_mems.wh_mem[rec_base + r]);
      end
    end
    if (wh_data !== exp_q[n - 1]) begin
      errors++;
      $display("Mismatch %s wh_data_o: expected %h, actual %h",
               case_name[c], exp_q[n - 1], wh_data);
    end
    // write address keeps running across starts
    if (wh_addr !== `SPMM_WH_ADDR_W'(rec_base + n)) begin
      errors++;
      $display("Mismatch %s wh_addr_o: expected %0d, actual %0d",
               case_name[c], rec_base + n, wh_addr);
    end
    rec_base += n;
  endtask

  initial begin
    rst_n    = 1'b0;
    start    = 1'b0;
    num_rows = '0;
    errors   = 0;
    rec_base = 0;
    repeat (5) @(posedge clk);
    #2 rst_n = 1'b1;
    if (done || wh_ena || wh_addr !== '0) begin
      errors++;
      $display("DUT outputs were not idle after reset");
    end
    for (int c = 0; c < NUM_CASES; c++) begin
      load_memories(c);
      compute_expected(c);
      @(posedge clk);
      #2;
      start    = 1'b1;
      num_rows = `SPMM_INFO_ADDR_W'(case_rows[c]);
      @(posedge clk);
      #2;
      start = 1'b0;
      while (!done) begin
        @(posedge clk);
        #2;
      end
      check_results(c);
    end
    $display("Summary: %0d errors over %0d cases", errors, NUM_CASES);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: done_o did not rise within %0d cycles", WATCHDOG_CYCLES);
    $display("Summary: %0d errors plus a timeout", errors);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== testbench/tb_spmm_mems.sv ====
`timescale 1ns/100ps
`include "spmm_settings.svh"

// synchronous memory models, data one cycle after the address
module tb_spmm_mems import spmm_pkg::*; (
  input  logic                                          clk,
  input  logic [`SPMM_INFO_ADDR_W-1:0]                  info_addr_i,
  output node_info_t                                    info_dout_o,
  input  logic [`SPMM_H_ADDR_W-1:0]                     h_addr_i,
  output nz_t                                           h_dout_o,
  input  logic [`SPMM_NUM_COLS-1:0][`SPMM_COL_IDX_W-1:0] wgt_addr_i,
  output logic [`SPMM_NUM_COLS-1:0][`SPMM_DATA_W-1:0]    wgt_dout_o,
  input  wh_t                                           wh_din_i,
  input  logic                                          wh_ena_i,
  input  logic [`SPMM_WH_ADDR_W-1:0]                    wh_addr_i
);

  node_info_t                     info_mem [2**`SPMM_INFO_ADDR_W];
  nz_t                            h_mem [2**`SPMM_H_ADDR_W];
  logic signed [`SPMM_DATA_W-1:0] wgt_mem [2**`SPMM_COL_IDX_W][`SPMM_NUM_COLS];
  wh_t                            wh_mem [2**`SPMM_WH_ADDR_W];
  int                             wh_count;
  int                             seed;

  initial begin
    seed        = 32'h1e31_1571;
    wh_count    = 0;
    info_dout_o = '0;
    h_dout_o    = '0;
    wgt_dout_o  = '0;
    // one weight per row and lane
    for (int r = 0; r < 2**`SPMM_COL_IDX_W; r++) begin
      for (int l = 0; l < `SPMM_NUM_COLS; l++) begin
        wgt_mem[r][l] = `SPMM_DATA_W'($random(seed));
      end
    end
  end

  always @(posedge clk) begin
    info_dout_o <= info_mem[info_addr_i];
    h_dout_o    <= h_mem[h_addr_i];
    for (int l = 0; l < `SPMM_NUM_COLS; l++) begin
      wgt_dout_o[l] <= wgt_mem[wgt_addr_i[l]][l];
    end
    // every result write is kept, count tells how many arrived
    if (wh_ena_i) begin
      wh_mem[wh_addr_i] <= wh_din_i;
      wh_count          <= wh_count + 1;
    end
  end

endmodule
